// ==== flist.f ====
source/sdo_pkg.sv
source/sdo_frame_rx.sv
source/object_dictionary.sv
source/sdo_frame_tx.sv
source/sdo_server_top.sv
testbench/tb_clock_gen.sv
testbench/tb_sdo_server.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the SDO server testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_sdo_server -f flist.f \
  -Mdir obj_dir -o sim_sdo_server
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

output=$(./obj_dir/sim_sdo_server)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "RESULT: PASS"; then
  exit 0
fi
exit 1

// ==== source/object_dictionary.sv ====
`timescale 1ns/1ps

module object_dictionary (
  input  logic                  clk,
  input  logic                  rst,

  input  logic                  rq_valid,
  output logic                  rq_ready,
  input  sdo_pkg::sdo_request_t rq,

  output logic                  rp_valid,
  input  logic                  rp_ready,
  output sdo_pkg::sdo_reply_t   rp
);

  import sdo_pkg::*;

  logic [31:0]               user_regs [num_user_regs];
  logic [user_sel_width-1:0] user_sel;

  logic        known_index;
  logic        known_sub;
  logic        read_only;
  logic [31:0] entry_value;
  logic        do_write;
  logic        take;
  sdo_reply_t  reply;

  assign rq_ready = !rp_valid || rp_ready;
  assign take     = rq_valid && rq_ready;
  assign user_sel = rq.subindex[user_sel_width-1:0];

  // Dictionary lookup
  always_comb
  begin
    known_index = 1'b0;
    known_sub   = 1'b0;
    read_only   = 1'b1;
    entry_value = 32'h0;
    case (rq.index)
      idx_device_type:
      begin
        known_index = 1'b1;
        known_sub   = (rq.subindex == sub_device_type);
        entry_value = dev_type_value;
      end
      idx_identity:
      begin
        known_index = 1'b1;
        known_sub   = (rq.subindex == sub_vendor_id);
        entry_value = vendor_id_value;
      end
      idx_user_regs:
      begin
        known_index = 1'b1;
        known_sub   = (rq.subindex < num_user_regs);
        read_only   = 1'b0;
        entry_value = user_regs[user_sel];
      end
      default:
      begin
        known_index = 1'b0;
      end
    endcase
  end

  // Checks in priority order, index and subindex always echoed
  always_comb
  begin
    do_write       = 1'b0;
    reply.index    = rq.index;
    reply.subindex = rq.subindex;
    reply.command  = cmd_abort;
    reply.data     = abort_bad_cmd;
    if (rq.op != op_read && rq.op != op_write)
    begin
      reply.data = abort_bad_cmd;
    end
    else if (!known_index)
    begin
      reply.data = abort_no_object;
    end
    else if (!known_sub)
    begin
      reply.data = abort_no_subindex;
    end
    else if (rq.op == op_write && read_only)
    begin
      reply.data = abort_read_only;
    end
    else if (rq.op == op_write)
    begin
      do_write      = 1'b1;
      reply.command = cmd_download_resp;
      reply.data    = 32'h0;
    end
    else
    begin
      reply.command = cmd_upload_resp;
      reply.data    = entry_value;
    end
  end

  // Write lands on the accepting edge so any later read sees it
  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      for (int i = 0; i < num_user_regs; i++)
      begin
        user_regs[i] <= 32'h0;
      end
    end
    else if (take && do_write)
    begin
      user_regs[user_sel] <= rq.data;
    end
  end

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      rp_valid <= 1'b0;
    end
    else if (rq_ready)
    begin
      rp_valid <= rq_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    if (take)
    begin
      rp <= reply;
    end
  end

endmodule

// ==== source/sdo_frame_rx.sv ====
`timescale 1ns/1ps

module sdo_frame_rx (
  input  logic                  clk,
  input  logic                  rst,

  input  logic                  req_valid,
  output logic                  req_ready,
  input  sdo_pkg::sdo_frame_t   req_frame,

  input  sdo_pkg::node_id_t     node_id,

  output logic                  rq_valid,
  input  logic                  rq_ready,
  output sdo_pkg::sdo_request_t rq
);

  import sdo_pkg::*;

  logic [11:0]  own_cob_id;
  logic         own_frame;
  logic         accept;
  sdo_op_e      op_decoded;
  sdo_request_t rq_next;

  // Requests for this node arrive on 600h + node
  assign own_cob_id = cob_rx_base + {5'b0, node_id};
  assign own_frame  = (req_frame.cob_id == own_cob_id);

  // Slot takes a new frame when empty or draining this cycle
  assign req_ready = !rq_valid || rq_ready;
  assign accept    = req_valid && req_ready;

  always_comb
  begin
    case (req_frame.command)
      cmd_upload_req:
      begin
        op_decoded = op_read;
      end
      cmd_download_req:
      begin
        op_decoded = op_write;
      end
      default:
      begin
        op_decoded = op_bad_cmd;
      end
    endcase
  end

  always_comb
  begin
    rq_next.op       = op_decoded;
    rq_next.index    = req_frame.index;
    rq_next.subindex = req_frame.subindex;
    rq_next.data     = req_frame.data;
  end

  // Foreign frames are consumed but never fill the slot
  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      rq_valid <= 1'b0;
    end
    else if (req_ready)
    begin
      rq_valid <= req_valid && own_frame;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept && own_frame)
    begin
      rq <= rq_next;
    end
  end

endmodule

// ==== source/sdo_frame_tx.sv ====
`timescale 1ns/1ps

module sdo_frame_tx (
  input  logic                clk,
  input  logic                rst,

  input  logic                rp_valid,
  output logic                rp_ready,
  input  sdo_pkg::sdo_reply_t rp,

  input  sdo_pkg::node_id_t   node_id,

  output logic                resp_valid,
  input  logic                resp_ready,
  output sdo_pkg::sdo_frame_t resp_frame
);

  import sdo_pkg::*;

  logic [frame_width-1:0] frame_q;
  logic [11:0]            tx_cob_id;
  sdo_frame_t             frame_next;
  logic                   take;

  // Responses go out on 580h + node
  assign tx_cob_id = cob_tx_base + {5'b0, node_id};

  assign rp_ready = !resp_valid || resp_ready;
  assign take     = rp_valid && rp_ready;

  always_comb
  begin
    frame_next.cob_id   = tx_cob_id;
    frame_next.command  = rp.command;
    frame_next.index    = rp.index;
    frame_next.subindex = rp.subindex;
    frame_next.data     = rp.data;
  end

  // Frame stays put while the hub stalls
  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      resp_valid <= 1'b0;
    end
    else if (rp_ready)
    begin
      resp_valid <= rp_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    if (take)
    begin
      frame_q <= frame_next;
    end
  end

  assign resp_frame = sdo_frame_t'(frame_q);

endmodule

// ==== source/sdo_pkg.sv ====
package sdo_pkg;

  // Width of a request or response frame on the hub link
  localparam int frame_width = 76;

  typedef logic [6:0] node_id_t;

  typedef struct packed {
    logic [11:0] cob_id;
    logic [7:0]  command;
    logic [15:0] index;
    logic [7:0]  subindex;
    logic [31:0] data;
  } sdo_frame_t;

  // SDO command bytes, expedited transfers only
  typedef enum logic [7:0] {
    cmd_upload_req    = 8'h40,
    cmd_download_req  = 8'h23,
    cmd_upload_resp   = 8'h43,
    cmd_download_resp = 8'h60,
    cmd_abort         = 8'h80
  } sdo_cmd_e;

  typedef enum logic [1:0] {
    op_read,
    op_write,
    op_bad_cmd
  } sdo_op_e;

  // Decoded request handed to the dictionary
  typedef struct packed {
    sdo_op_e     op;
    logic [15:0] index;
    logic [7:0]  subindex;
    logic [31:0] data;
  } sdo_request_t;

  // Data holds the read value or the abort code
  typedef struct packed {
    sdo_cmd_e    command;
    logic [15:0] index;
    logic [7:0]  subindex;
    logic [31:0] data;
  } sdo_reply_t;

  // COB-ID bases, node number is added
  localparam logic [11:0] cob_rx_base = 12'h600;
  localparam logic [11:0] cob_tx_base = 12'h580;

  // Object dictionary layout
  localparam logic [15:0] idx_device_type = 16'h1000;
  localparam logic [7:0]  sub_device_type = 8'h00;
  localparam logic [15:0] idx_identity    = 16'h1018;
  localparam logic [7:0]  sub_vendor_id   = 8'h01;
  localparam logic [15:0] idx_user_regs   = 16'h2000;

  localparam int num_user_regs  = 4;
  localparam int user_sel_width = $clog2(num_user_regs);

  localparam logic [31:0] dev_type_value  = 32'h0000_0191;
  localparam logic [31:0] vendor_id_value = 32'h1234_5678;

  // SDO abort codes
  localparam logic [31:0] abort_bad_cmd     = 32'h0504_0001;
  localparam logic [31:0] abort_read_only   = 32'h0601_0002;
  localparam logic [31:0] abort_no_object   = 32'h0602_0000;
  localparam logic [31:0] abort_no_subindex = 32'h0609_0011;

endpackage

// ==== source/sdo_server_top.sv ====
`timescale 1ns/1ps

module sdo_server_top (
  input  logic                clk,
  input  logic                rst,
  input  sdo_pkg::node_id_t   node_id,

  input  logic                req_valid,
  output logic                req_ready,
  input  sdo_pkg::sdo_frame_t req_frame,

  output logic                resp_valid,
  input  logic                resp_ready,
  output sdo_pkg::sdo_frame_t resp_frame
);

  import sdo_pkg::*;

  logic         rq_valid;
  logic         rq_ready;
  sdo_request_t rq;

  logic         rp_valid;
  logic         rp_ready;
  sdo_reply_t   rp;

  sdo_frame_rx i_frame_rx (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req_frame (req_frame),
    .node_id   (node_id),
    .rq_valid  (rq_valid),
    .rq_ready  (rq_ready),
    .rq        (rq)
  );

  object_dictionary i_object_dictionary (
    .clk      (clk),
    .rst      (rst),
    .rq_valid (rq_valid),
    .rq_ready (rq_ready),
    .rq       (rq),
    .rp_valid (rp_valid),
    .rp_ready (rp_ready),
    .rp       (rp)
  );

  sdo_frame_tx i_frame_tx (
    .clk        (clk),
    .rst        (rst),
    .rp_valid   (rp_valid),
    .rp_ready   (rp_ready),
    .rp         (rp),
    .node_id    (node_id),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp_frame (resp_frame)
  );

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  // 100 ns period
  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Reset held low for 4 cycles
  initial
  begin
    rst = 1'b0;
    repeat (4) @(posedge clk);
    rst <= 1'b1;
  end

endmodule

// ==== testbench/tb_sdo_server.sv ====
`timescale 1ns/1ps

module tb_sdo_server;

  import sdo_pkg::*;

  localparam int num_requests = 400;
  localparam int cycle_ns     = 100;
  localparam int watchdog_ns  = num_requests * 20 * cycle_ns;

  localparam node_id_t    own_node     = 7'h05;
  localparam logic [11:0] own_req_cob  = 12'h605;
  localparam logic [11:0] own_resp_cob = 12'h585;

  logic        clk;
  logic        rst;
  logic        req_valid;
  logic        req_ready;
  sdo_frame_t  req_frame;
  logic        resp_valid;
  logic        resp_ready;
  sdo_frame_t  resp_frame;

  logic [31:0] lfsr;
  logic [31:0] model_regs [4];
  sdo_frame_t  expected_q [$];
  logic        next_valid;
  sdo_frame_t  next_frame;

  int sent;
  int expected_total;
  int received;
  int mismatch_count;
  int other_count;

  tb_clock_gen i_clock_gen (
    .clk (clk),
    .rst (rst)
  );

  sdo_server_top i_dut (
    .clk        (clk),
    .rst        (rst),
    .node_id    (own_node),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req_frame  (req_frame),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp_frame (resp_frame)
  );

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic pick_request(output logic valid, output sdo_frame_t f);
    node_id_t other;
    f     = '0;
    valid = (sent < num_requests) && (2'(take_bits(2)) != 2'd0);
    case (3'(take_bits(3)))
      3'd0, 3'd1, 3'd2, 3'd3: f.command = cmd_upload_req;
      3'd7:                   f.command = 8'(take_bits(8));
      default:                f.command = cmd_download_req;
    endcase
    case (3'(take_bits(3)))
      3'd0:    f.index = idx_device_type;
      3'd1:    f.index = idx_identity;
      3'd7:    f.index = 16'(take_bits(16));
      default: f.index = idx_user_regs;
    endcase
    f.subindex = 8'(take_bits(8) % 6);
    f.data     = take_bits(32);
    // About one frame in eight goes to another node
    if (3'(take_bits(3)) == 3'd0)
    begin
      other = 7'(take_bits(7));
      if (other == own_node)
        other = own_node + 7'd1;
      f.cob_id = 12'h600 + {5'b0, other};
    end
    else
      f.cob_id = own_req_cob;
  endtask

  // Expected response for one accepted request to this node
  task automatic model_request(input sdo_frame_t f);
    sdo_frame_t e;
    logic       is_read;
    logic       is_write;
    logic       known_idx;
    logic       known_sub;
    logic [31:0] value;
    is_read   = (f.command == 8'h40);
    is_write  = (f.command == 8'h23);
    known_idx = 1'b1;
    known_sub = 1'b0;
    value     = 32'h0;
    case (f.index)
      16'h1000:
      begin
        known_sub = (f.subindex == 8'h00);
        value     = 32'h0000_0191;
      end
      16'h1018:
      begin
        known_sub = (f.subindex == 8'h01);
        value     = 32'h1234_5678;
      end
      16'h2000:
      begin
        known_sub = (f.subindex < 8'd4);
        value     = model_regs[f.subindex[1:0]];
      end
      default: known_idx = 1'b0;
    endcase
    e.cob_id   = own_resp_cob;
    e.index    = f.index;
    e.subindex = f.subindex;
    e.command  = 8'h80;
    if (!is_read && !is_write)
      e.data = 32'h0504_0001;
    else if (!known_idx)
      e.data = 32'h0602_0000;
    else if (!known_sub)
      e.data = 32'h0609_0011;
    else if (is_write && f.index != 16'h2000)
      e.data = 32'h0601_0002;
    else if (is_write)
    begin
      model_regs[f.subindex[1:0]] = f.data;
      e.command = 8'h60;
      e.data    = 32'h0;
    end
    else
    begin
      e.command = 8'h43;
      e.data    = value;
    end
    expected_q.push_back(e);
    expected_total++;
  endtask

  task automatic check_response(input sdo_frame_t got, input sdo_frame_t exp);
    if (got !== exp)
    begin
      $display("mismatch at %0t ns: resp_frame got %h expected %h", $time, got, exp);
      mismatch_count++;
    end
  endtask

  task automatic check_count(input int got, input int exp);
    if (got != exp)
    begin
      $display("mismatch at %0t ns: response count got %0d expected %0d", $time, got, exp);
      mismatch_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
      mismatch_count++;
    end
  endtask

  always @(posedge clk)
  begin
    if (rst)
    begin
      if (req_valid && req_ready)
      begin
        // Foreign frames are dropped and touch no register
        if (req_frame.cob_id == own_req_cob)
          model_request(req_frame);
        sent++;
      end
      if (resp_valid && resp_ready)
      begin
        received++;
        if (expected_q.size() == 0)
        begin
          $display("unexpected response at %0t ns with no request outstanding", $time);
          other_count++;
        end
        else
          check_response(resp_frame, expected_q.pop_front());
      end
      // New request only once the current one has been taken
      if (!req_valid || req_ready)
      begin
        pick_request(next_valid, next_frame);
        req_valid <= next_valid;
        req_frame <= next_frame;
      end
      resp_ready <= (3'(take_bits(3)) >= 3'd3);
    end
  end

  initial
  begin
    lfsr           = 32'hf2fd_94f5;
    req_valid      = 1'b0;
    req_frame      = '0;
    resp_ready     = 1'b0;
    sent           = 0;
    expected_total = 0;
    received       = 0;
    mismatch_count = 0;
    other_count    = 0;
    for (int i = 0; i < 4; i++)
      model_regs[i] = 32'h0;
    @(posedge clk);
    @(negedge clk);
    check_flag("resp_valid", resp_valid, 1'b0);
    check_flag("req_ready", req_ready, 1'b1);
    wait (rst === 1'b1);
    while (sent < num_requests || expected_q.size() != 0)
      @(negedge clk);
    // Room for any stray response behind the last one
    repeat (8) @(negedge clk);
    check_count(received, expected_total);
    $display("errors: %0d mismatch, %0d other (%0d requests, %0d responses)",
             mismatch_count, other_count, sent, received);
    if (mismatch_count == 0 && other_count == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

  initial
  begin
    #(watchdog_ns);
    $display("timeout after %0d ns with %0d requests sent and %0d responses pending",
             watchdog_ns, sent, expected_q.size());
    $display("RESULT: FAIL");
    $finish;
  end

endmodule
